/* verilog.f */
hw/sram_test_pkg.sv
hw/axi_lite_pkg.sv
hw/sram_pattern_generator.sv
hw/sram_test_sequencer.sv
hw/axi_lite_master_port.sv
hw/sram_read_checker.sv
hw/axi_sram_controller.sv
hw/sram_tester_axi.sv
verif/sram_model.sv
verif/tb_sram_tester.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sram_tester
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_sram_tester.sv */
`timescale 1ns/10ps

module tb_sram_tester;

  // per pass 32 writes at 3 cycles and 32 reads at 4, five patterns, three tests, doubled
  localparam int TIMEOUT_CYCLES = (32 * 3 + 32 * 4) * 5 * 3 * 2;
  localparam int SPAN           = 32;

  logic                         clk;
  logic                         reset;
  logic                         test_done;
  logic                         test_pass;
  sram_test_pkg::pattern_kind_t pattern_state;
  sram_test_pkg::sram_data_t    read_data;
  sram_test_pkg::sram_data_t    expected_data;
  sram_test_pkg::sram_addr_t    iter_addr;
  sram_test_pkg::sram_addr_t    sram_io_addr;
  wire sram_test_pkg::sram_data_t sram_io_data;
  logic                         sram_io_we_n;
  logic                         sram_io_oe_n;
  logic                         sram_io_ce_n;
  logic                         fault_enable;
  sram_test_pkg::sram_addr_t    fault_addr;
  logic [3:0]                   fault_bit;

  int                           phase;
  int                           cycle_count;
  int                           done_count;
  int                           oe_low_cnt;
  int                           since_fault;
  int                           pend_cycles;
  logic                         fault_seen;
  logic                         seen_write;
  logic                         wrote_since_check;
  logic                         prev_done;
  sram_test_pkg::pattern_kind_t prev_kind;
  sram_test_pkg::pattern_kind_t write_kind;
  sram_test_pkg::sram_data_t    exp_word;
  sram_test_pkg::sram_data_t    pend_word;
  sram_test_pkg::sram_data_t    pend_read;
  sram_test_pkg::sram_addr_t    prev_iter;

  sram_tester_axi #(
    .ADDR_BITS(5)
  ) dut0 (
    .clk(clk), .reset(reset), .test_done(test_done), .test_pass(test_pass),
    .pattern_state(pattern_state), .read_data(read_data), .expected_data(expected_data),
    .iter_addr(iter_addr), .sram_io_addr(sram_io_addr), .sram_io_data(sram_io_data),
    .sram_io_we_n(sram_io_we_n), .sram_io_oe_n(sram_io_oe_n), .sram_io_ce_n(sram_io_ce_n)
  );

  sram_model mem0 (
    .addr(sram_io_addr), .data(sram_io_data), .we_n(sram_io_we_n), .oe_n(sram_io_oe_n),
    .ce_n(sram_io_ce_n), .fault_enable(fault_enable), .fault_addr(fault_addr),
    .fault_bit(fault_bit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // word each pattern kind puts at an address
  function automatic sram_test_pkg::sram_data_t pattern_word(
    input sram_test_pkg::pattern_kind_t kind,
    input sram_test_pkg::sram_addr_t    addr
  );
    case (kind)
      sram_test_pkg::PAT_ZEROS:   pattern_word = 16'h0000;
      sram_test_pkg::PAT_ONES:    pattern_word = 16'hffff;
      sram_test_pkg::PAT_CHECK_A: pattern_word = 16'h5555;
      sram_test_pkg::PAT_CHECK_B: pattern_word = 16'haaaa;
      sram_test_pkg::PAT_ADDR:    pattern_word = addr[15:0];
      default:                    pattern_word = 16'h0000;
    endcase
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_text(input string text);
    $display("%s at %0t ns", text, $time);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    assert (test_pass) else report_value("test_pass", 32'(test_pass), 32'd1);
    assert (sram_io_we_n && sram_io_oe_n && sram_io_ce_n)
      else report_text("SRAM strobes active right after reset");
  endtask

  // sweep of the tested span in the model after a write pass
  task automatic check_memory(input sram_test_pkg::pattern_kind_t kind);
    sram_test_pkg::sram_data_t want;
    for (int a = 0; a < SPAN; a++) begin
      want = pattern_word(kind, sram_test_pkg::sram_addr_t'(a));
      assert (mem0.mem[a] == want) else report_value("mem", 32'(mem0.mem[a]), 32'(want));
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test never finished", cycle_count);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  // all clocked checks sample at the falling edge where outputs are stable
  always @(negedge clk) begin
    if (reset) begin
      seen_write        = 1'b0;
      wrote_since_check = 1'b0;
      prev_done         = 1'b0;
      prev_kind         = sram_test_pkg::PAT_ZEROS;
      write_kind        = sram_test_pkg::PAT_ZEROS;
      oe_low_cnt        = 0;
      pend_cycles       = 0;
      prev_iter         = '0;
    end else begin
      // pin protocol
      assert (sram_io_we_n || sram_io_oe_n) else report_text("we_n and oe_n low together");
      assert (sram_io_we_n || !sram_io_ce_n) else report_text("we_n low with ce_n high");
      assert (sram_io_oe_n || !sram_io_ce_n) else report_text("oe_n low with ce_n high");
      if (sram_io_we_n && sram_io_oe_n) begin
        assert (sram_io_data === 16'hzzzz)
          else report_text("DUT drives the data bus outside a write strobe");
      end
      if (!seen_write) begin
        assert (sram_io_oe_n && (sram_io_ce_n || !sram_io_we_n))
          else report_text("SRAM strobes active before the first write");
      end

      // address counter walks the tested span one step at a time
      assert (iter_addr < SPAN) else report_text("iter_addr outside the tested span");
      if (iter_addr != prev_iter) begin
        assert (iter_addr == (prev_iter + 1) % SPAN)
          else report_value("iter_addr", 32'(iter_addr), 32'((prev_iter + 1) % SPAN));
      end

      // pattern order and done pulse
      if (test_done) begin
        assert (pattern_state == sram_test_pkg::PAT_ADDR)
          else report_value("pattern_state", 32'(pattern_state), 32'(sram_test_pkg::PAT_ADDR));
        assert (!prev_done) else report_text("test_done high for more than one cycle");
        assert (phase == 1) else report_text("test_done pulsed after the fault");
        done_count++;
      end
      if (pattern_state != prev_kind) begin
        if (prev_kind == sram_test_pkg::PAT_ADDR) begin
          assert (prev_done && pattern_state == sram_test_pkg::PAT_ZEROS)
            else report_text("pattern did not restart after test_done");
        end else begin
          assert (32'(pattern_state) == 32'(prev_kind) + 1)
            else report_value("pattern_state", 32'(pattern_state), 32'(prev_kind) + 1);
        end
      end

      // write strobe
      if (!sram_io_we_n) begin
        assert (sram_io_addr < SPAN) else report_text("write outside the tested span");
        exp_word = pattern_word(pattern_state, sram_io_addr);
        assert (sram_io_data == exp_word)
          else report_value("sram_io_data", 32'(sram_io_data), 32'(exp_word));
        assert (!fault_seen) else report_text("write strobe after the fault");
        write_kind        = pattern_state;
        seen_write        = 1'b1;
        wrote_since_check = 1'b1;
      end

      // compared pair shows up two cycles after the data sample
      if (pend_cycles > 0) begin
        pend_cycles--;
        if (pend_cycles == 0) begin
          assert (expected_data == pend_word)
            else report_value("expected_data", 32'(expected_data), 32'(pend_word));
          assert (read_data == pend_read)
            else report_value("read_data", 32'(read_data), 32'(pend_read));
        end
      end

      // read strobe, data is sampled in its second cycle
      if (!sram_io_oe_n) begin
        if (wrote_since_check) begin
          check_memory(write_kind);
          wrote_since_check = 1'b0;
        end
        if (oe_low_cnt == 1) begin
          exp_word  = pattern_word(write_kind, sram_io_addr);
          pend_word = exp_word;
          pend_read = exp_word;
          if (fault_enable && sram_io_addr == fault_addr) begin
            pend_read[fault_bit] = 1'b0;
          end
          pend_cycles = 2;
          if (phase == 1) begin
            assert (sram_io_data == exp_word)
              else report_value("sram_io_data", 32'(sram_io_data), 32'(exp_word));
          end else if (fault_enable && sram_io_addr == fault_addr && exp_word[fault_bit]
                       && !fault_seen) begin
            fault_seen  = 1'b1;
            since_fault = 0;
          end
        end
        oe_low_cnt++;
      end else begin
        oe_low_cnt = 0;
      end

      // sticky pass flag, falls the cycle after the failing beat
      if (fault_seen) begin
        since_fault++;
      end
      if (fault_seen && since_fault >= 3) begin
        assert (!test_pass) else report_value("test_pass", 32'(test_pass), 32'd0);
      end else begin
        assert (test_pass) else report_value("test_pass", 32'(test_pass), 32'd1);
      end

      prev_done = test_done;
      prev_kind = pattern_state;
      prev_iter = iter_addr;
    end
  end

  initial begin
    void'($urandom(32'h3546056d));
    reset        = 1'b1;
    fault_enable = 1'b0;
    fault_addr   = '0;
    fault_bit    = '0;
    phase        = 1;
    cycle_count  = 0;
    done_count   = 0;
    since_fault  = 0;
    fault_seen   = 1'b0;

    apply_reset();
    while (done_count < 2) @(posedge clk);

    // phase 2, one stuck bit on one address
    #1;
    fault_addr = sram_test_pkg::sram_addr_t'($urandom_range(SPAN - 1, 0));
    fault_bit  = 4'($urandom_range(15, 0));
    phase      = 2;
    apply_reset();
    while (pattern_state != sram_test_pkg::PAT_ONES) begin
      @(posedge clk);
      #1;
    end
    fault_enable = 1'b1;
    while (test_pass) @(posedge clk);
    // halted sequencer must stay quiet
    repeat (200) @(posedge clk);

    if (fault_seen && !test_pass) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_text("Fault read never seen or test_pass recovered");
    end
  end

endmodule

/* verif/sram_model.sv */
`timescale 1ns/10ps

module sram_model (
  input  sram_test_pkg::sram_addr_t   addr,
  inout  wire sram_test_pkg::sram_data_t data,
  input  logic                        we_n,
  input  logic                        oe_n,
  input  logic                        ce_n,
  input  logic                        fault_enable,
  input  sram_test_pkg::sram_addr_t   fault_addr,
  input  logic [3:0]                  fault_bit
);

  logic [15:0] mem [0:(1<<20)-1];

  sram_test_pkg::sram_data_t rd_word;
  logic                      drive;

  // level sensitive write while both strobes are low
  always @(we_n or ce_n or addr or data) begin
    if (!we_n && !ce_n) begin
      mem[addr] = data;
    end
  end

  // stuck at zero bit shows up on the read path only
  always_comb begin
    rd_word = mem[addr];
    if (fault_enable && (addr == fault_addr)) begin
      rd_word[fault_bit] = 1'b0;
    end
  end

  assign drive = !oe_n && !ce_n && we_n;
  assign data  = drive ? rd_word : 'z;

endmodule

/* hw/sram_tester_axi.sv */
`timescale 1ns/10ps

module sram_tester_axi #(
  parameter int ADDR_BITS = 20
) (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_test_pkg::pattern_kind_t pattern_state,
  output sram_test_pkg::sram_data_t    read_data,
  output sram_test_pkg::sram_data_t    expected_data,
  output sram_test_pkg::sram_addr_t    iter_addr,
  output sram_test_pkg::sram_addr_t    sram_io_addr,
  inout  wire sram_test_pkg::sram_data_t sram_io_data,
  output logic                         sram_io_we_n,
  output logic                         sram_io_oe_n,
  output logic                         sram_io_ce_n
);

  // decode to execute to result
  sram_test_pkg::mem_op_t    op;
  logic                      op_issue;
  logic                      op_accepted;
  logic                      expect_push;
  sram_test_pkg::sram_data_t expect_data;

  // AXI-Lite channels between master and controller
  axi_lite_pkg::axi_addr_chan_t  aw;
  logic                          awvalid;
  logic                          awready;
  axi_lite_pkg::axi_wdata_chan_t w;
  logic                          wvalid;
  logic                          wready;
  logic                          bvalid;
  logic                          bready;
  axi_lite_pkg::axi_resp_t       bresp;
  axi_lite_pkg::axi_addr_chan_t  ar;
  logic                          arvalid;
  logic                          arready;
  axi_lite_pkg::axi_rdata_chan_t r;
  logic                          rvalid;
  logic                          rready;

  sram_test_sequencer #(
    .ADDR_BITS(ADDR_BITS)
  ) seq (
    .clk(clk), .reset(reset), .test_pass(test_pass), .op_accepted(op_accepted),
    .op(op), .op_issue(op_issue), .test_done(test_done),
    .pattern_state(pattern_state), .iter_addr(iter_addr)
  );

  axi_lite_master_port master (
    .clk(clk), .reset(reset), .op(op), .op_issue(op_issue), .op_accepted(op_accepted),
    .expect_push(expect_push), .expect_data(expect_data),
    .aw(aw), .awvalid(awvalid), .awready(awready), .w(w), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .ar(ar), .arvalid(arvalid), .arready(arready)
  );

  sram_read_checker chk (
    .clk(clk), .reset(reset), .expect_push(expect_push), .expect_data(expect_data),
    .r(r), .rvalid(rvalid), .rready(rready), .test_pass(test_pass),
    .read_data(read_data), .expected_data(expected_data)
  );

  axi_sram_controller ctrl (
    .clk(clk), .reset(reset),
    .aw(aw), .awvalid(awvalid), .awready(awready), .w(w), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .ar(ar), .arvalid(arvalid), .arready(arready), .r(r), .rvalid(rvalid), .rready(rready),
    .sram_io_addr(sram_io_addr), .sram_io_data(sram_io_data), .sram_io_we_n(sram_io_we_n),
    .sram_io_oe_n(sram_io_oe_n), .sram_io_ce_n(sram_io_ce_n)
  );

endmodule

/* hw/axi_sram_controller.sv */
`timescale 1ns/10ps

module axi_sram_controller (
  input  logic                              clk,
  input  logic                              reset,
  input  axi_lite_pkg::axi_addr_chan_t      aw,
  input  logic                              awvalid,
  output logic                              awready,
  input  axi_lite_pkg::axi_wdata_chan_t     w,
  input  logic                              wvalid,
  output logic                              wready,
  output logic                              bvalid,
  input  logic                              bready,
  output axi_lite_pkg::axi_resp_t           bresp,
  input  axi_lite_pkg::axi_addr_chan_t      ar,
  input  logic                              arvalid,
  output logic                              arready,
  output axi_lite_pkg::axi_rdata_chan_t     r,
  output logic                              rvalid,
  input  logic                              rready,
  output sram_test_pkg::sram_addr_t         sram_io_addr,
  inout  wire sram_test_pkg::sram_data_t    sram_io_data,
  output logic                              sram_io_we_n,
  output logic                              sram_io_oe_n,
  output logic                              sram_io_ce_n
);

  typedef enum logic [2:0] {
    CT_IDLE,
    CT_WR_STROBE,
    CT_WR_RESP,
    CT_RD_WAIT,
    CT_RD_RESP
  } ctrl_state_t;

  ctrl_state_t               state;
  ctrl_state_t               next_state;
  logic                      rd_wait_cnt;
  logic                      wr_accept;
  logic                      rd_accept;
  logic                      drive_data;
  sram_test_pkg::sram_addr_t addr_q;
  sram_test_pkg::sram_data_t wdata_q;
  sram_test_pkg::sram_data_t rdata_q;

  // writes need AW and W together and win over a pending read
  assign wr_accept = (state == CT_IDLE) && awvalid && wvalid;
  assign arready   = (state == CT_IDLE) && !(awvalid && wvalid);
  assign rd_accept = arready && arvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  assign bvalid = (state == CT_WR_RESP);
  assign bresp  = axi_lite_pkg::RESP_OKAY;
  assign rvalid = (state == CT_RD_RESP);
  assign r.data = rdata_q;
  assign r.resp = axi_lite_pkg::RESP_OKAY;

  always_comb begin
    next_state = state;
    case (state)
      CT_IDLE: begin
        if (wr_accept) next_state = CT_WR_STROBE;
        else if (rd_accept) next_state = CT_RD_WAIT;
      end
      CT_WR_STROBE: next_state = CT_WR_RESP;
      CT_WR_RESP: if (bready) next_state = CT_IDLE;
      // two cycles of output enable before sampling
      CT_RD_WAIT: if (rd_wait_cnt) next_state = CT_RD_RESP;
      CT_RD_RESP: if (rready) next_state = CT_IDLE;
      default: next_state = CT_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= CT_IDLE;
      rd_wait_cnt  <= 1'b0;
      sram_io_we_n <= 1'b1;
      sram_io_oe_n <= 1'b1;
      sram_io_ce_n <= 1'b1;
      drive_data   <= 1'b0;
    end else begin
      state        <= next_state;
      rd_wait_cnt  <= (state == CT_RD_WAIT) && !rd_wait_cnt;
      // pin strobes registered from the next state, glitch free
      sram_io_ce_n <= !(next_state == CT_WR_STROBE || next_state == CT_RD_WAIT);
      sram_io_we_n <= (next_state != CT_WR_STROBE);
      sram_io_oe_n <= (next_state != CT_RD_WAIT);
      drive_data   <= (next_state == CT_WR_STROBE);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      addr_q  <= aw.addr;
      wdata_q <= w.data;
    end else if (rd_accept) begin
      addr_q <= ar.addr;
    end
    if (state == CT_RD_WAIT && rd_wait_cnt) rdata_q <= sram_io_data;
  end

  assign sram_io_addr = addr_q;
  assign sram_io_data = drive_data ? wdata_q : 'z;

endmodule

/* hw/sram_read_checker.sv */
`timescale 1ns/10ps

module sram_read_checker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          expect_push,
  input  sram_test_pkg::sram_data_t     expect_data,
  input  axi_lite_pkg::axi_rdata_chan_t r,
  input  logic                          rvalid,
  output logic                          rready,
  output logic                          test_pass,
  output sram_test_pkg::sram_data_t     read_data,
  output sram_test_pkg::sram_data_t     expected_data
);

  localparam int DEPTH = 4;

  sram_test_pkg::sram_data_t fifo_mem [DEPTH];
  logic [1:0]                wr_ptr;
  logic [1:0]                rd_ptr;
  logic [2:0]                count;
  logic                      beat;
  logic                      push;
  logic                      pop;
  logic                      mismatch;

  assign beat = rvalid && rready;
  assign push = expect_push && (count != 3'(DEPTH));
  assign pop  = beat && (count != 3'd0);

  // data with nothing expected counts as a failure too
  assign mismatch = (count == 3'd0) || (r.data != fifo_mem[rd_ptr]);

  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= expect_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      rready    <= 1'b0;
      test_pass <= 1'b1;
    end else begin
      rready <= 1'b1;
      if (push) wr_ptr <= wr_ptr + 2'd1;
      if (pop) rd_ptr <= rd_ptr + 2'd1;
      count <= count + 3'(push) - 3'(pop);
      // sticky until reset
      if (beat && mismatch) test_pass <= 1'b0;
    end
  end

  // last compared pair
  always_ff @(posedge clk) begin
    if (beat) begin
      read_data     <= r.data;
      expected_data <= fifo_mem[rd_ptr];
    end
  end

endmodule

/* hw/axi_lite_master_port.sv */
`timescale 1ns/10ps

module axi_lite_master_port (
  input  logic                          clk,
  input  logic                          reset,
  input  sram_test_pkg::mem_op_t        op,
  input  logic                          op_issue,
  output logic                          op_accepted,
  output logic                          expect_push,
  output sram_test_pkg::sram_data_t     expect_data,
  output axi_lite_pkg::axi_addr_chan_t  aw,
  output logic                          awvalid,
  input  logic                          awready,
  output axi_lite_pkg::axi_wdata_chan_t w,
  output logic                          wvalid,
  input  logic                          wready,
  input  logic                          bvalid,
  output logic                          bready,
  input  axi_lite_pkg::axi_resp_t       bresp,
  output axi_lite_pkg::axi_addr_chan_t  ar,
  output logic                          arvalid,
  input  logic                          arready
);

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic aw_done;
  logic w_done;
  logic write_accepted;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign ar_hs = arvalid && arready;

  // both write beats seen, either earlier or in this cycle
  assign write_accepted = (aw_done || aw_hs) && (w_done || w_hs);
  assign op_accepted    = write_accepted || ar_hs;

  always_ff @(posedge clk) begin
    if (reset) begin
      awvalid     <= 1'b0;
      wvalid      <= 1'b0;
      arvalid     <= 1'b0;
      bready      <= 1'b0;
      aw_done     <= 1'b0;
      w_done      <= 1'b0;
      expect_push <= 1'b0;
    end else begin
      bready      <= 1'b1;
      expect_push <= op_issue && !op.is_write;
      if (op_issue && op.is_write) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (aw_hs) awvalid <= 1'b0;
        if (w_hs) wvalid <= 1'b0;
      end
      if (op_issue && !op.is_write) begin
        arvalid <= 1'b1;
      end else if (ar_hs) begin
        arvalid <= 1'b0;
      end
      // sticky beat flags, cleared once the write counts as accepted
      if (write_accepted) begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end else begin
        if (aw_hs) aw_done <= 1'b1;
        if (w_hs) w_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (op_issue && op.is_write) begin
      aw.addr <= op.addr;
      w.data  <= op.data;
    end else if (op_issue) begin
      ar.addr     <= op.addr;
      expect_data <= op.data;
    end
  end

endmodule

/* hw/sram_test_sequencer.sv */
`timescale 1ns/10ps

module sram_test_sequencer #(
  parameter int ADDR_BITS = 20
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         test_pass,
  input  logic                         op_accepted,
  output sram_test_pkg::mem_op_t       op,
  output logic                         op_issue,
  output logic                         test_done,
  output sram_test_pkg::pattern_kind_t pattern_state,
  output sram_test_pkg::sram_addr_t    iter_addr
);

  sram_test_pkg::seq_state_t state;
  sram_test_pkg::seq_state_t next_state;

  logic [ADDR_BITS-1:0]      addr_cnt;
  logic                      last_op;
  logic                      issue_write;
  logic                      issue_read;
  logic                      advance;
  logic                      restart;
  logic                      last_kind;
  sram_test_pkg::sram_data_t pattern;

  sram_pattern_generator pattern_gen (
    .clk      (clk),
    .reset    (reset),
    .restart  (restart),
    .advance  (advance),
    .addr     (iter_addr),
    .pattern  (pattern),
    .kind     (pattern_state),
    .last_kind(last_kind)
  );

  always_comb begin
    next_state  = state;
    issue_write = 1'b0;
    issue_read  = 1'b0;
    advance     = 1'b0;
    restart     = 1'b0;
    case (state)
      sram_test_pkg::ST_START, sram_test_pkg::ST_NEXT_PATTERN: begin
        issue_write = 1'b1;
        next_state  = sram_test_pkg::ST_WRITE;
      end
      sram_test_pkg::ST_WRITE: begin
        if (op_accepted && last_op) begin
          issue_read = 1'b1;
          next_state = sram_test_pkg::ST_READ;
        end else if (op_accepted) begin
          issue_write = 1'b1;
        end
      end
      sram_test_pkg::ST_READ: begin
        if (op_accepted && last_op) begin
          advance    = !last_kind;
          next_state = last_kind ? sram_test_pkg::ST_DONE : sram_test_pkg::ST_NEXT_PATTERN;
        end else if (op_accepted) begin
          issue_read = 1'b1;
        end
      end
      sram_test_pkg::ST_DONE: begin
        restart    = 1'b1;
        next_state = sram_test_pkg::ST_START;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= sram_test_pkg::ST_START;
      addr_cnt <= '0;
      last_op  <= 1'b0;
    end else begin
      state <= test_pass ? next_state : sram_test_pkg::ST_HALT;
      // counter wraps to zero after the last address of a pass
      if (op_issue) begin
        addr_cnt <= addr_cnt + 1'b1;
        last_op  <= (addr_cnt == '1);
      end
    end
  end

  // high address bits outside the tested span stay zero
  assign iter_addr   = sram_test_pkg::sram_addr_t'(addr_cnt);
  assign op_issue    = (issue_write || issue_read) && test_pass;
  assign op.is_write = issue_write;
  assign op.addr     = iter_addr;
  assign op.data     = pattern;
  assign test_done   = (state == sram_test_pkg::ST_DONE);

endmodule

/* hw/sram_pattern_generator.sv */
`timescale 1ns/10ps

module sram_pattern_generator (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         restart,
  input  logic                         advance,
  input  sram_test_pkg::sram_addr_t    addr,
  output sram_test_pkg::sram_data_t    pattern,
  output sram_test_pkg::pattern_kind_t kind,
  output logic                         last_kind
);

  sram_test_pkg::pattern_kind_t kind_next;

  // step to the next kind, wrap after the address pattern
  always_comb begin
    if (kind == sram_test_pkg::PAT_ADDR) begin
      kind_next = sram_test_pkg::PAT_ZEROS;
    end else begin
      kind_next = sram_test_pkg::pattern_kind_t'(kind + 3'd1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      kind <= sram_test_pkg::PAT_ZEROS;
    end else if (advance) begin
      kind <= kind_next;
    end
  end

  // pattern word from kind and address
  always_comb begin
    case (kind)
      sram_test_pkg::PAT_ZEROS:   pattern = 16'h0000;
      sram_test_pkg::PAT_ONES:    pattern = 16'hffff;
      sram_test_pkg::PAT_CHECK_A: pattern = 16'h5555;
      sram_test_pkg::PAT_CHECK_B: pattern = 16'haaaa;
      sram_test_pkg::PAT_ADDR:    pattern = addr[15:0];
      default:                    pattern = 16'h0000;
    endcase
  end

  assign last_kind = (kind == sram_test_pkg::PAT_ADDR);

endmodule

/* hw/axi_lite_pkg.sv */
package axi_lite_pkg;

  // response code, carried on B and R
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // AW and AR payload
  typedef struct packed {
    sram_test_pkg::sram_addr_t addr;
  } axi_addr_chan_t;

  // W payload, strobes are implied all ones
  typedef struct packed {
    sram_test_pkg::sram_data_t data;
  } axi_wdata_chan_t;

  // R payload
  typedef struct packed {
    sram_test_pkg::sram_data_t data;
    axi_resp_t                 resp;
  } axi_rdata_chan_t;

endpackage

/* hw/sram_test_pkg.sv */
package sram_test_pkg;

  // word address as seen on the sram pins
  typedef logic [19:0] sram_addr_t;

  // one sram data word
  typedef logic [15:0] sram_data_t;

  // patterns in the order the test runs them
  typedef enum logic [2:0] {
    PAT_ZEROS   = 3'd0,
    PAT_ONES    = 3'd1,
    PAT_CHECK_A = 3'd2,
    PAT_CHECK_B = 3'd3,
    PAT_ADDR    = 3'd4
  } pattern_kind_t;

  // decode stage states
  typedef enum logic [2:0] {
    ST_START,
    ST_WRITE,
    ST_READ,
    ST_NEXT_PATTERN,
    ST_DONE,
    ST_HALT
  } seq_state_t;

  // one memory operation, data is the expected word for a read
  typedef struct packed {
    logic       is_write;
    sram_addr_t addr;
    sram_data_t data;
  } mem_op_t;

endpackage
